// File: include/vga_lb_defines.svh
// ====================
// Small test canvas, not a real monitor timing
// FIFO depth must be a power of two
// ====================
`ifndef VGA_LB_DEFINES_SVH
`define VGA_LB_DEFINES_SVH

// Active pixels per line
`define VGA_LB_CANVAS_W 16

// Active lines per frame
`define VGA_LB_CANVAS_H 4

// Blank cycles after each active line
`define VGA_LB_HBLANK 6

// Blank lines after each frame
`define VGA_LB_VBLANK 1

// Two pixels per 16-bit SRAM word
`define VGA_LB_FRAME_WORDS ((`VGA_LB_CANVAS_W * `VGA_LB_CANVAS_H) / 2)

// Line FIFO depth in words
`define VGA_LB_FIFO_DEPTH 16

// Reads pause here, slack covers rd_en register plus SRAM latency
`define VGA_LB_HMARK (`VGA_LB_FIFO_DEPTH - 4)

// One full line of words, needed before a frame starts
`define VGA_LB_LMARK (`VGA_LB_CANVAS_W / 2)

`endif

// File: src/vga_lb_pkg.sv
// ====================
// Widths follow the canvas and FIFO macros
// ====================
`include "vga_lb_defines.svh"

package vga_lb_pkg;

  // Word address width covers one frame
  localparam int SRAM_ADDR_W = $clog2(`VGA_LB_FRAME_WORDS);

  // Occupancy needs one bit over the FIFO index
  localparam int FF_OCC_W = $clog2(`VGA_LB_FIFO_DEPTH) + 1;

  // Raw SRAM data word
  typedef logic [15:0] sram_word_t;

  // One display pixel, half a word
  typedef logic [7:0] pixel_t;

  // Frame store word address
  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

  // Line FIFO fill level
  typedef logic [FF_OCC_W-1:0] ff_occ_t;

  // Raster driver states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_FILL,
    ACTIVE,
    HBLANK,
    VBLANK
  } drv_state_e;

endpackage

// File: src/vga_lb_intf.sv
// ====================
// Single clock domain, reset is synchronous active high
// ====================
`include "vga_lb_defines.svh"

// Clock and reset bundle
interface cr_intf;
  logic clk;
  logic rst;
endinterface

// SRAM read port plus the line buffer flow strobes
interface sram_rd_intf;
  import vga_lb_pkg::*;

  sram_addr_t addr;
  logic       rd_en;
  logic       rdy;
  sram_word_t rd_data;
  logic       rd_valid;
  logic       overflow;
  logic       underflow;

  // Line buffer side, requests and reports
  modport lb (
    output addr, rd_en, overflow, underflow,
    input  rdy, rd_data, rd_valid
  );
endinterface

// Pixel stream between line buffer and driver
interface pix_ff_intf;
  import vga_lb_pkg::*;

  logic   rd_en;
  pixel_t rd_data;
  logic   empty;
  logic   line_ready;

  // Producer, shows the head pixel while not empty
  modport src (
    input  rd_en,
    output rd_data, empty, line_ready
  );

  // Consumer, pops one pixel per rd_en cycle
  modport snk (
    output rd_en,
    input  rd_data, empty, line_ready
  );
endinterface

// File: src/vga_lb_fifo.sv
// ====================
// First-word-fall-through, head word is combinational
// Write when full and read when empty are dropped
// ====================
`include "vga_lb_defines.svh"

module vga_lb_fifo (
  cr_intf                         cr,
  input  logic                    wr_en,
  input  vga_lb_pkg::sram_word_t  wr_data,
  input  logic                    rd_en,
  output vga_lb_pkg::sram_word_t  rd_data,
  output logic                    empty,
  output logic                    full,
  output vga_lb_pkg::ff_occ_t     occ
);

  import vga_lb_pkg::*;

  localparam int IDX_W = $clog2(`VGA_LB_FIFO_DEPTH);

  // Word storage
  sram_word_t mem [`VGA_LB_FIFO_DEPTH];

  // Pointers wrap naturally at the power of two depth
  logic [IDX_W-1:0] wr_ptr;
  logic [IDX_W-1:0] rd_ptr;

  // Qualified requests
  logic wr_ok;
  logic rd_ok;

  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  // Flags straight from the fill count
  assign empty = (occ == '0);
  assign full  = (occ == ff_occ_t'(`VGA_LB_FIFO_DEPTH));

  // Head of queue falls through
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge cr.clk)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge cr.clk)
  begin
    if (cr.rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end
    else
    begin
      if (wr_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({wr_ok, rd_ok})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

endmodule

// File: src/vga_line_bffr.sv
// ====================
// Reads the frame store in order and wraps at frame end
// Pauses only on the high mark, sram rdy stalls the address
// ====================
`include "vga_lb_defines.svh"

module vga_line_bffr (
  cr_intf          cr,
  sram_rd_intf.lb  sram,
  pix_ff_intf.src  pix,
  input logic      vga_en
);

  import vga_lb_pkg::*;

  localparam sram_addr_t LAST_ADDR = sram_addr_t'(`VGA_LB_FRAME_WORDS - 1);

  // High byte select, low byte goes out first
  logic sel_hi;

  // Address stepping
  logic addr_inc;
  logic addr_wrap;

  // FIFO side
  sram_word_t ff_head;
  ff_occ_t    ff_occ;
  logic       ff_empty;
  logic       ff_full;
  logic       ff_pop;
  logic       pix_take;
  logic       below_hmark;

  // A request is taken when both sides agree
  assign addr_inc  = sram.rd_en & sram.rdy;
  assign addr_wrap = addr_inc & (sram.addr == LAST_ADDR);

  assign below_hmark = (ff_occ < ff_occ_t'(`VGA_LB_HMARK));

  always_ff @(posedge cr.clk)
  begin
    if (cr.rst)
    begin
      sram.addr  <= '0;
      sram.rd_en <= 1'b0;
    end
    else
    begin
      // Keep requesting while enabled and there is room
      sram.rd_en <= vga_en & below_hmark;
      if (addr_wrap)
      begin
        sram.addr <= '0;
      end
      else if (addr_inc)
      begin
        sram.addr <= sram.addr + 1'b1;
      end
    end
  end

  // Only a read of a real pixel advances the byte select
  assign pix_take = pix.rd_en & ~ff_empty;

  // Word leaves the FIFO once its high byte is taken
  assign ff_pop = pix_take & sel_hi;

  always_ff @(posedge cr.clk)
  begin
    if (cr.rst)
    begin
      sel_hi <= 1'b0;
    end
    else if (pix_take)
    begin
      sel_hi <= ~sel_hi;
    end
  end

  vga_lb_fifo u_fifo (
    .cr      (cr),
    .wr_en   (sram.rd_valid),
    .wr_data (sram.rd_data),
    .rd_en   (ff_pop),
    .rd_data (ff_head),
    .empty   (ff_empty),
    .full    (ff_full),
    .occ     (ff_occ)
  );

  // Byte unpack
  assign pix.rd_data = sel_hi ? ff_head[15:8] : ff_head[7:0];
  assign pix.empty   = ff_empty;

  // Enough words for one whole line
  assign pix.line_ready = (ff_occ >= ff_occ_t'(`VGA_LB_LMARK));

  // Single-cycle error strobes
  assign sram.overflow  = sram.rd_valid & ff_full;
  assign sram.underflow = pix.rd_en & ff_empty;

endmodule

// File: src/vga_pixel_drvr.sv
// ====================
// Fixed raster once started, does not wait on an empty buffer
// Disable takes effect at the next line end
// ====================
`include "vga_lb_defines.svh"

module vga_pixel_drvr (
  cr_intf                     cr,
  pix_ff_intf.snk             pix,
  input  logic                vga_en,
  output vga_lb_pkg::pixel_t  pix_data,
  output logic                pix_valid,
  output logic                hsync,
  output logic                vsync
);

  import vga_lb_pkg::*;

  localparam int LINE_LEN = `VGA_LB_CANVAS_W + `VGA_LB_HBLANK;
  localparam int COL_W    = $clog2(LINE_LEN);
  localparam int LINE_MAX = (`VGA_LB_CANVAS_H > `VGA_LB_VBLANK) ?
                            `VGA_LB_CANVAS_H : `VGA_LB_VBLANK;
  localparam int LINE_W   = (LINE_MAX > 1) ? $clog2(LINE_MAX) : 1;

  // Counter end points
  localparam logic [COL_W-1:0]  ACT_LAST  = COL_W'(`VGA_LB_CANVAS_W - 1);
  localparam logic [COL_W-1:0]  HB_LAST   = COL_W'(`VGA_LB_HBLANK - 1);
  localparam logic [COL_W-1:0]  LINE_LAST = COL_W'(LINE_LEN - 1);
  localparam logic [COL_W-1:0]  VB_HSYNC  = COL_W'(`VGA_LB_CANVAS_W);
  localparam logic [LINE_W-1:0] H_LAST    = LINE_W'(`VGA_LB_CANVAS_H - 1);
  localparam logic [LINE_W-1:0] VB_LAST   = LINE_W'(`VGA_LB_VBLANK - 1);

  drv_state_e        state;
  logic [COL_W-1:0]  col;
  logic [LINE_W-1:0] line;
  logic              pix_rd;
  logic              hsync_nxt;

  // One pixel per active cycle
  assign pix_rd     = (state == ACTIVE);
  assign pix.rd_en  = pix_rd;

  // Blank start of every line, vblank lines keep the same position
  assign hsync_nxt = ((state == HBLANK) && (col == '0)) ||
                     ((state == VBLANK) && (col == VB_HSYNC));

  always_ff @(posedge cr.clk)
  begin
    if (cr.rst)
    begin
      state <= IDLE;
      col   <= '0;
      line  <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          col  <= '0;
          line <= '0;
          if (vga_en)
          begin
            state <= WAIT_FILL;
          end
        end
        WAIT_FILL:
        begin
          // Start time depends on how fast the buffer fills
          if (!vga_en)
          begin
            state <= IDLE;
          end
          else if (pix.line_ready)
          begin
            state <= ACTIVE;
          end
        end
        ACTIVE:
        begin
          if (col == ACT_LAST)
          begin
            col   <= '0;
            state <= HBLANK;
          end
          else
          begin
            col <= col + 1'b1;
          end
        end
        HBLANK:
        begin
          if (col == HB_LAST)
          begin
            col <= '0;
            if (!vga_en)
            begin
              state <= IDLE;
            end
            else if (line == H_LAST)
            begin
              line  <= '0;
              state <= VBLANK;
            end
            else
            begin
              line  <= line + 1'b1;
              state <= ACTIVE;
            end
          end
          else
          begin
            col <= col + 1'b1;
          end
        end
        VBLANK:
        begin
          // Whole blank lines, then straight into the next frame
          if (col == LINE_LAST)
          begin
            col <= '0;
            if (!vga_en)
            begin
              state <= IDLE;
            end
            else if (line == VB_LAST)
            begin
              line  <= '0;
              state <= ACTIVE;
            end
            else
            begin
              line <= line + 1'b1;
            end
          end
          else
          begin
            col <= col + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Syncs delayed to line up with the registered pixel
  always_ff @(posedge cr.clk)
  begin
    if (cr.rst)
    begin
      pix_valid <= 1'b0;
      hsync     <= 1'b0;
      vsync     <= 1'b0;
    end
    else
    begin
      pix_valid <= pix_rd;
      hsync     <= hsync_nxt;
      vsync     <= (state == VBLANK);
    end
  end

  always_ff @(posedge cr.clk)
  begin
    if (pix_rd)
    begin
      pix_data <= pix.rd_data;
    end
  end

endmodule

// File: src/vga_lb_top.sv
// ====================
// SRAM side is ready/valid with in-order returns
// Error outputs are one-cycle strobes
// ====================
`include "vga_lb_defines.svh"

module vga_lb_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    vga_en,
  output vga_lb_pkg::sram_addr_t  sram_addr,
  output logic                    sram_rd_en,
  input  logic                    sram_rdy,
  input  vga_lb_pkg::sram_word_t  sram_rd_data,
  input  logic                    sram_rd_valid,
  output vga_lb_pkg::pixel_t      pix_data,
  output logic                    pix_valid,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    bffr_overflow,
  output logic                    bffr_underflow
);

  cr_intf      cr ();
  sram_rd_intf sram ();
  pix_ff_intf  pix ();

  // Clock and reset into the bundle
  assign cr.clk = clk;
  assign cr.rst = rst;

  // SRAM inputs in
  assign sram.rdy      = sram_rdy;
  assign sram.rd_data  = sram_rd_data;
  assign sram.rd_valid = sram_rd_valid;

  // SRAM requests and flow strobes out
  assign sram_addr      = sram.addr;
  assign sram_rd_en     = sram.rd_en;
  assign bffr_overflow  = sram.overflow;
  assign bffr_underflow = sram.underflow;

  vga_line_bffr u_line_bffr (
    .cr     (cr),
    .sram   (sram.lb),
    .pix    (pix.src),
    .vga_en (vga_en)
  );

  vga_pixel_drvr u_pixel_drvr (
    .cr        (cr),
    .pix       (pix.snk),
    .vga_en    (vga_en),
    .pix_data  (pix_data),
    .pix_valid (pix_valid),
    .hsync     (hsync),
    .vsync     (vsync)
  );

endmodule

// File: sim/vga_lb_checker.sv
// ====================
// Bound to the top level ports
// Sampled on the rising clock edge
// ====================

module vga_lb_checker (
  input logic clk,
  input logic rst,
  input logic vga_en,
  input logic sram_rd_en,
  input logic pix_valid,
  input logic hsync,
  input logic bffr_overflow
);

  // Failed assertion count that the testbench reads at the end
  int fail_count = 0;

  // Set once vga_en has been seen since the last reset
  logic en_seen;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      en_seen <= 1'b0;
    end
    else if (vga_en)
    begin
      en_seen <= 1'b1;
    end
  end

  // Request strobe is cleared by reset and stays low while it lasts
  rd_en_reset_chk: assert property (@(posedge clk) rst |=> !sram_rd_en)
    else
    begin
      $error("sram_rd_en high while rst is high");
      fail_count++;
    end

  // High mark leaves enough slack for every request in flight
  no_overflow_chk: assert property (@(posedge clk) disable iff (rst) !bffr_overflow)
    else
    begin
      $error("bffr_overflow pulsed");
      fail_count++;
    end

  // Sync pulse opens the blank in the cycle after the last pixel of a line
  hsync_line_end_chk: assert property (@(posedge clk) disable iff (rst) $fell(pix_valid) |-> hsync)
    else
    begin
      $error("hsync missing in the cycle after the last pixel of a line");
      fail_count++;
    end

  // No pixel before the display is enabled
  quiet_start_chk: assert property (@(posedge clk) disable iff (rst) !en_seen |-> !pix_valid)
    else
    begin
      $error("pix_valid high before vga_en was seen");
      fail_count++;
    end

endmodule

bind vga_lb_top vga_lb_checker u_checker (
  .clk           (clk),
  .rst           (rst),
  .vga_en        (vga_en),
  .sram_rd_en    (sram_rd_en),
  .pix_valid     (pix_valid),
  .hsync         (hsync),
  .bffr_overflow (bffr_overflow)
);

// File: sim/vga_lb_tb.sv
// ====================
// Directed tests with an SRAM model of fixed 2-cycle latency
// Inputs change 2 units after the rising edge, outputs sampled at the falling edge
// ====================
`include "vga_lb_defines.svh"

module vga_lb_tb;

  import vga_lb_pkg::*;

  // Raster and frame sizes
  localparam int LINE_CYC    = `VGA_LB_CANVAS_W + `VGA_LB_HBLANK;
  localparam int FRAME_LINES = `VGA_LB_CANVAS_H + `VGA_LB_VBLANK;
  localparam int FRAME_CYC   = LINE_CYC * FRAME_LINES;
  localparam int FRAME_PIX   = `VGA_LB_CANVAS_W * `VGA_LB_CANVAS_H;
  localparam int FRAME_WORDS = `VGA_LB_FRAME_WORDS;

  // Tests span about ten frames including resets and fill waits
  localparam int CYCLE_LIMIT = 12 * FRAME_CYC;

  // SRAM ready modes
  localparam int RDY_HIGH = 0;
  localparam int RDY_LCG  = 1;
  localparam int RDY_LOW  = 2;

  logic       clk;
  logic       rst;
  logic       vga_en;
  sram_addr_t sram_addr;
  logic       sram_rd_en;
  logic       sram_rdy;
  sram_word_t sram_rd_data;
  logic       sram_rd_valid;
  pixel_t     pix_data;
  logic       pix_valid;
  logic       hsync;
  logic       vsync;
  logic       bffr_overflow;
  logic       bffr_underflow;

  int          errors    = 0;
  int          checks    = 0;
  int          cycles    = 0;
  int unsigned lcg_state = 93;
  int          rdy_mode  = RDY_HIGH;

  // Request seen this cycle and the one waiting for its return
  logic       req_v  = 1'b0;
  sram_addr_t req_a  = '0;
  logic       pipe_v = 1'b0;
  sram_addr_t pipe_a = '0;

  // Accepted addresses in order
  sram_addr_t acc_q [$];

  vga_lb_top UUT (
    .clk            (clk),
    .rst            (rst),
    .vga_en         (vga_en),
    .sram_addr      (sram_addr),
    .sram_rd_en     (sram_rd_en),
    .sram_rdy       (sram_rdy),
    .sram_rd_data   (sram_rd_data),
    .sram_rd_valid  (sram_rd_valid),
    .pix_data       (pix_data),
    .pix_valid      (pix_valid),
    .hsync          (hsync),
    .vsync          (vsync),
    .bffr_overflow  (bffr_overflow),
    .bffr_underflow (bffr_underflow)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // Low byte 2a, high byte 2a+1, both modulo 256
  function automatic sram_word_t sram_word(sram_addr_t a);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = 8'((2 * int'(a)) % 256);
    hi = 8'((2 * int'(a) + 1) % 256);
    return {hi, lo};
  endfunction

  // Pixel k of the stream, word address wraps at the frame end
  function automatic pixel_t expected_pixel(int k);
    int word_addr;
    word_addr = (k / 2) % FRAME_WORDS;
    return pixel_t'((2 * word_addr + (k % 2)) % 256);
  endfunction

  // Requests are taken at the next rising edge
  always @(negedge clk)
  begin
    req_v = !rst && sram_rd_en && sram_rdy;
    req_a = sram_addr;
    if (req_v)
    begin
      acc_q.push_back(sram_addr);
    end
  end

  // Data returns two cycles after the request cycle
  always @(posedge clk)
  begin
    #2;
    sram_rd_valid = pipe_v;
    sram_rd_data  = pipe_v ? sram_word(pipe_a) : '0;
    pipe_v        = req_v && !rst;
    pipe_a        = req_a;
    case (rdy_mode)
      RDY_HIGH: sram_rdy = 1'b1;
      RDY_LCG:  sram_rdy = (lcg_next() % 4) != 0;
      default:  sram_rdy = 1'b0;
    endcase
  end

  task automatic report_error(string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic check_pixel(string name, pixel_t got, pixel_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(string name, sram_addr_t got, sram_addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Mode change lands at the falling edge, away from the model update
  task automatic set_rdy_mode(int mode);
    @(negedge clk);
    rdy_mode = mode;
  endtask

  task automatic drive_enable(logic value);
    @(posedge clk);
    #2;
    vga_en = value;
  endtask

  task automatic apply_reset();
    int i;
    set_rdy_mode(RDY_HIGH);
    @(posedge clk);
    #2;
    rst    = 1'b1;
    vga_en = 1'b0;
    for (i = 0; i < 5; i++)
    begin
      @(posedge clk);
    end
    #2;
    rst = 1'b0;
    acc_q.delete();
  endtask

  // Pixels in counter order and requested addresses in wrap order
  task automatic check_stream(int npix, output int n_addr);
    int         got_pix;
    int         waited;
    int         limit;
    sram_addr_t exp_addr;
    got_pix  = 0;
    waited   = 0;
    n_addr   = 0;
    exp_addr = '0;
    limit    = (npix / FRAME_PIX + 1) * FRAME_CYC;
    while (got_pix < npix && waited < limit)
    begin
      @(negedge clk);
      waited++;
      check_bit("bffr_overflow", bffr_overflow, 1'b0);
      check_bit("bffr_underflow", bffr_underflow, 1'b0);
      if (pix_valid)
      begin
        check_pixel("pix_data", pix_data, expected_pixel(got_pix));
        got_pix++;
      end
      while (acc_q.size() > 0)
      begin
        check_addr("sram_addr", acc_q.pop_front(), exp_addr);
        n_addr++;
        exp_addr = (int'(exp_addr) == FRAME_WORDS - 1) ? '0 : exp_addr + 1'b1;
      end
    end
    if (got_pix < npix)
    begin
      report_error($sformatf("only %0d of %0d pixels arrived", got_pix, npix));
    end
  endtask

  task automatic wait_first_pixel(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < FRAME_CYC)
    begin
      @(negedge clk);
      n++;
      seen = pix_valid;
    end
  endtask

  task automatic test_reset_state();
    int i;
    apply_reset();
    for (i = 0; i < 3 * LINE_CYC; i++)
    begin
      @(negedge clk);
      check_bit("sram_rd_en", sram_rd_en, 1'b0);
      check_bit("pix_valid", pix_valid, 1'b0);
      check_bit("hsync", hsync, 1'b0);
      check_bit("vsync", vsync, 1'b0);
      check_bit("bffr_overflow", bffr_overflow, 1'b0);
      check_bit("bffr_underflow", bffr_underflow, 1'b0);
      check_addr("sram_addr", sram_addr, '0);
    end
  endtask

  task automatic test_pixel_order();
    int n_addr;
    apply_reset();
    drive_enable(1'b1);
    check_stream(FRAME_PIX, n_addr);
    drive_enable(1'b0);
  endtask

  task automatic test_frame_wrap();
    int n_addr;
    apply_reset();
    drive_enable(1'b1);
    // Second frame must restart at pixel zero
    check_stream(2 * FRAME_PIX, n_addr);
    if (n_addr <= FRAME_WORDS)
    begin
      report_error("sram_addr never passed the frame wrap");
    end
    drive_enable(1'b0);
  endtask

  task automatic test_raster_shape();
    bit seen;
    int p;
    int col;
    int line;
    apply_reset();
    drive_enable(1'b1);
    wait_first_pixel(seen);
    if (!seen)
    begin
      report_error("pix_valid never rose after vga_en");
    end
    else
    begin
      // Cycle p counts from the first pixel of the frame
      for (p = 0; p < 2 * FRAME_CYC; p++)
      begin
        if (p > 0)
        begin
          @(negedge clk);
        end
        col  = p % LINE_CYC;
        line = (p / LINE_CYC) % FRAME_LINES;
        check_bit("pix_valid", pix_valid,
                  (line < `VGA_LB_CANVAS_H) && (col < `VGA_LB_CANVAS_W));
        check_bit("hsync", hsync, col == `VGA_LB_CANVAS_W);
        check_bit("vsync", vsync, line >= `VGA_LB_CANVAS_H);
      end
    end
    drive_enable(1'b0);
  endtask

  task automatic test_flow_control();
    int n_addr;
    int under;
    int i;
    apply_reset();
    set_rdy_mode(RDY_LCG);
    drive_enable(1'b1);
    check_stream(2 * FRAME_PIX, n_addr);
    // Starve the buffer for several lines
    set_rdy_mode(RDY_LOW);
    under = 0;
    for (i = 0; i < 5 * LINE_CYC; i++)
    begin
      @(negedge clk);
      check_bit("bffr_overflow", bffr_overflow, 1'b0);
      if (bffr_underflow)
      begin
        under++;
      end
    end
    if (under == 0)
    begin
      report_error("bffr_underflow never pulsed while sram_rdy was held low");
    end
    drive_enable(1'b0);
    set_rdy_mode(RDY_HIGH);
  endtask

  initial
  begin
    rst           = 1'b1;
    vga_en        = 1'b0;
    sram_rdy      = 1'b0;
    sram_rd_valid = 1'b0;
    sram_rd_data  = '0;
    test_reset_state();
    test_pixel_order();
    test_frame_wrap();
    test_raster_shape();
    test_flow_control();
    if (UUT.u_checker.fail_count != 0)
    begin
      report_error("bound assertions failed, see messages above");
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/vga_lb_pkg.sv
src/vga_lb_intf.sv
src/vga_lb_fifo.sv
src/vga_line_bffr.sv
src/vga_pixel_drvr.sv
src/vga_lb_top.sv
sim/vga_lb_checker.sv
sim/vga_lb_tb.sv

// File: Bender.yml
package:
  name: vga_lb

sources:
  - include_dirs:
      - include
    files:
      - src/vga_lb_pkg.sv
      - src/vga_lb_intf.sv
      - src/vga_lb_fifo.sv
      - src/vga_line_bffr.sv
      - src/vga_pixel_drvr.sv
      - src/vga_lb_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/vga_lb_checker.sv
      - sim/vga_lb_tb.sv
